//--- Makefile
# Verilator build of the LCD subsystem testbench

TOP = tb_lcd_subsys

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -f sim.f \
		--top-module $(TOP) -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- rtl/fb_ram.sv
//--------------------
// single-port framebuffer, one 24-bit pixel per word
// synchronous write, read data valid the cycle after the request
//--------------------
`default_nettype none
`timescale 1ns/100ps

module fb_ram (
	input  logic               clk,
	input  lcd_pkg::mem_req_t  req,
	output logic [23:0]        rdata
);
	import lcd_pkg::*;

	logic [23:0] mem [FB_DEPTH];

	always_ff @(posedge clk) begin
		if (req.en) begin
			if (req.we)
				mem[req.addr] <= req.wdata;
			else
				rdata <= mem[req.addr];  // registered read
		end
	end

endmodule

`default_nettype wire

//--- rtl/lcd_iface.sv
//--------------------
// LCD register file and panel write/read sequencer
// also streams framebuffer pixels to the panel in line-render mode
//--------------------
`default_nettype none
`timescale 1ns/100ps

// control register bits
//   0 backlight enable
//   1 panel reset (pin driven inverted)
//   2 chip select
//   3 start render at the next frame start, sets bit 4 there
//   4 render streaming enabled
module lcd_iface (
	input  logic                clk,
	input  logic                nrst,
	input  lcd_pkg::reg_addr_e  addr,
	input  logic                wen,
	input  logic                ren,
	input  logic [31:0]         wdata,
	output logic [31:0]         rdata,
	output logic                ready,
	output logic                next_pixel,
	input  logic                newfield,
	input  logic                pix_wait,
	input  lcd_pkg::pixel_t     pixel,
	output lcd_pkg::lcd_pins_t  lcd,
	input  logic                lcd_id,
	input  logic                lcd_fmark
);
	import lcd_pkg::*;

	seq_state_e        state;
	logic [4:0]        ctl;
	logic [LCD_DW-1:0] start_cmd;
	logic [LCD_DW-1:0] readbuf;
	logic [LCD_DW-1:0] db_q;
	logic              rd_q;
	logic              wr_q;
	logic              rs_q;
	logic              is_write;
	logic              cpu_xfer;    // current sequence belongs to the cpu
	logic              sent_start;  // start command already out for this frame
	logic              ready_q;
	logic              cpu_req;
	logic              lcd_req;
	logic              vm_start;
	logic              vm_ena;

	assign cpu_req  = wen | ren;
	assign lcd_req  = (addr == REG_CMD) || (addr == REG_DATA);
	assign vm_start = ctl[3];
	assign vm_ena   = ctl[4] | (ctl[3] & newfield);

	always_comb begin
		case (addr)
			REG_CTL:    rdata = {27'b0, ctl};
			REG_STATUS: rdata = {30'b0, lcd_id, lcd_fmark};
			REG_START:  rdata = {14'b0, start_cmd};
			default:    rdata = {14'b0, readbuf};
		endcase
	end

	// registers answer next cycle, panel transfers once the strobe is done
	always_ff @(posedge clk) begin
		if (!nrst) begin
			ready_q <= 1'b0;
		end else if (lcd_req) begin
			ready_q <= (state == ST_STROBE) && cpu_xfer;
		end else begin
			ready_q <= cpu_req;
		end
	end

	assign ready = ready_q & cpu_req;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			ctl       <= CTL_RST;
			start_cmd <= START_CMD_RST;
		end else begin
			if (wen && addr == REG_CTL)
				ctl <= wdata[4:0];
			if (wen && addr == REG_START)
				start_cmd <= wdata[LCD_DW-1:0];
			if (vm_start && newfield)
				ctl[4] <= 1'b1;  // render armed, begin at frame start
		end
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state      <= ST_IDLE;
			db_q       <= '0;
			rd_q       <= 1'b1;
			wr_q       <= 1'b1;
			rs_q       <= 1'b0;
			is_write   <= 1'b0;
			cpu_xfer   <= 1'b0;
			sent_start <= 1'b0;
			next_pixel <= 1'b0;
		end else begin
			next_pixel <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (vm_ena) begin
						if (newfield && !sent_start) begin
							rs_q       <= 1'b0;
							db_q       <= start_cmd;
							is_write   <= 1'b1;
							cpu_xfer   <= 1'b0;
							sent_start <= 1'b1;
							state      <= ST_SETUP;
						end else if (!pix_wait) begin
							rs_q       <= 1'b1;
							db_q       <= {pixel.r[7:2], pixel.g[7:2], pixel.b[7:2]};
							next_pixel <= 1'b1;
							is_write   <= 1'b1;
							cpu_xfer   <= 1'b0;
							sent_start <= 1'b0;
							state      <= ST_SETUP;
						end
					end else if (lcd_req && cpu_req) begin
						rs_q <= (addr == REG_DATA);
						if (wen)
							db_q <= wdata[LCD_DW-1:0];  // reads leave the bus as is
						is_write <= wen;
						cpu_xfer <= 1'b1;
						state    <= ST_SETUP;
					end else if (vm_start && !pix_wait && !next_pixel) begin
						next_pixel <= 1'b1;  // skip ahead to pixel 0
					end
				end
				ST_SETUP: begin
					rd_q  <= is_write;
					wr_q  <= ~is_write;
					state <= ST_STROBE;
				end
				ST_STROBE: begin
					state <= ST_HOLD;
				end
				ST_HOLD: begin
					rd_q <= 1'b1;
					wr_q <= 1'b1;
					if (!cpu_xfer || !cpu_req) begin
						cpu_xfer <= 1'b0;
						state    <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// no panel input bus, readback is the word last driven
	always_ff @(posedge clk) begin
		if (state == ST_STROBE)
			readbuf <= db_q;
	end

	assign lcd = '{
		db:   db_q,
		rd:   rd_q,
		wr:   wr_q,
		rs:   rs_q,
		cs:   ctl[2],
		rst:  ~ctl[1],
		blen: ctl[0]
	};

	a_strobe_excl: assert property (@(posedge clk) disable iff (!nrst)
		lcd.wr || lcd.rd);

	// ready never shows up on the first cycle of a request
	a_ready_req: assert property (@(posedge clk) disable iff (!nrst)
		ready |-> $past(wen || ren));

endmodule

`default_nettype wire

//--- rtl/lcd_pkg.sv
//--------------------
// shared constants, register map and bus structs of the LCD subsystem
// pulled in by every RTL block and by the testbench
//--------------------
`default_nettype none

package lcd_pkg;

	localparam int FB_DEPTH = 64;           // pixels per frame
	localparam int FB_AW    = 6;            // framebuffer word address
	localparam int LCD_DW   = 18;           // panel bus, 6:6:6

	localparam logic [LCD_DW-1:0] START_CMD_RST = 18'h2c;  // memory write command
	localparam logic [4:0]        CTL_RST       = 5'h6;    // cs high, panel in reset

	// register word index, cpu byte address bits [4:2]
	typedef enum logic [2:0] {
		REG_CMD    = 3'd0,
		REG_DATA   = 3'd1,
		REG_CTL    = 3'd2,
		REG_STATUS = 3'd3,
		REG_START  = 3'd4
	} reg_addr_e;

	// panel write/read sequencer
	typedef enum logic [2:0] {
		ST_IDLE   = 3'd0,
		ST_SETUP  = 3'd1,
		ST_SPARE  = 3'd2,
		ST_STROBE = 3'd3,
		ST_HOLD   = 3'd4
	} seq_state_e;

	typedef struct packed {
		logic        sel_fb;   // 1 = framebuffer, 0 = lcd registers
		logic [7:0]  addr;     // byte address
		logic        wen;
		logic        ren;
		logic [31:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic             en;
		logic             we;
		logic [FB_AW-1:0] addr;
		logic [23:0]      wdata;
	} mem_req_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	typedef struct packed {
		logic [LCD_DW-1:0] db;
		logic              rd;     // active low
		logic              wr;     // active low
		logic              rs;     // 0 = command, 1 = data
		logic              cs;
		logic              rst;    // active low
		logic              blen;   // backlight
	} lcd_pins_t;

endpackage

`default_nettype wire

//--- rtl/lcd_subsys.sv
//--------------------
// LCD subsystem top, cpu bus in and 18-bit panel pins out
// framebuffer shared between the cpu and the pixel fetcher
//--------------------
`default_nettype none
`timescale 1ns/100ps

module lcd_subsys (
	input  logic                clk,
	input  logic                nrst,
	input  lcd_pkg::cpu_req_t   cpu,
	output logic [31:0]         rdata,
	output logic                ready,
	output lcd_pkg::lcd_pins_t  lcd,
	input  logic                lcd_id,
	input  logic                lcd_fmark
);
	import lcd_pkg::*;

	reg_addr_e   reg_addr;
	logic        reg_wen;
	logic        reg_ren;
	logic [31:0] reg_wdata;
	logic [31:0] reg_rdata;
	logic        reg_ready;

	mem_req_t    fetch_req;
	mem_req_t    mem_req;
	logic [23:0] fetch_rdata;
	logic [23:0] mem_rdata;

	logic        next_pixel;
	logic        newfield;
	logic        pix_wait;
	pixel_t      pixel;

	mem_arbiter u_mem_arbiter (
		.clk         (clk),
		.nrst        (nrst),
		.cpu         (cpu),
		.rdata       (rdata),
		.ready       (ready),
		.reg_addr    (reg_addr),
		.reg_wen     (reg_wen),
		.reg_ren     (reg_ren),
		.reg_wdata   (reg_wdata),
		.reg_rdata   (reg_rdata),
		.reg_ready   (reg_ready),
		.fetch_req   (fetch_req),
		.fetch_rdata (fetch_rdata),
		.mem_req     (mem_req),
		.mem_rdata   (mem_rdata)
	);

	lcd_iface u_lcd_iface (
		.clk        (clk),
		.nrst       (nrst),
		.addr       (reg_addr),
		.wen        (reg_wen),
		.ren        (reg_ren),
		.wdata      (reg_wdata),
		.rdata      (reg_rdata),
		.ready      (reg_ready),
		.next_pixel (next_pixel),
		.newfield   (newfield),
		.pix_wait   (pix_wait),
		.pixel      (pixel),
		.lcd        (lcd),
		.lcd_id     (lcd_id),
		.lcd_fmark  (lcd_fmark)
	);

	pixel_fetch u_pixel_fetch (
		.clk        (clk),
		.nrst       (nrst),
		.next_pixel (next_pixel),
		.mem_req    (fetch_req),
		.mem_rdata  (fetch_rdata),
		.pixel      (pixel),
		.newfield   (newfield),
		.pix_wait   (pix_wait)
	);

	fb_ram u_fb_ram (
		.clk   (clk),
		.req   (mem_req),
		.rdata (mem_rdata)
	);

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
//--------------------
// splits the cpu bus into register and framebuffer accesses
// shares fb_ram with pixel_fetch, the fetcher always wins
//--------------------
`default_nettype none
`timescale 1ns/100ps

module mem_arbiter (
	input  logic                clk,
	input  logic                nrst,
	input  lcd_pkg::cpu_req_t   cpu,
	output logic [31:0]         rdata,
	output logic                ready,
	output lcd_pkg::reg_addr_e  reg_addr,
	output logic                reg_wen,
	output logic                reg_ren,
	output logic [31:0]         reg_wdata,
	input  logic [31:0]         reg_rdata,
	input  logic                reg_ready,
	input  lcd_pkg::mem_req_t   fetch_req,
	output logic [23:0]         fetch_rdata,
	output lcd_pkg::mem_req_t   mem_req,
	input  logic [23:0]         mem_rdata
);
	import lcd_pkg::*;

	typedef enum logic {
		ARB_IDLE,
		ARB_FLIGHT   // cpu owned the memory last cycle
	} arb_state_e;

	arb_state_e  state;
	logic        fb_req;
	logic        cpu_gnt;
	logic        fb_done;     // cpu access finished, waiting for strobe drop
	logic [23:0] fb_rdata_q;

	assign reg_addr  = reg_addr_e'(cpu.addr[4:2]);
	assign reg_wen   = cpu.wen & ~cpu.sel_fb;
	assign reg_ren   = cpu.ren & ~cpu.sel_fb;
	assign reg_wdata = cpu.wdata;

	assign fb_req  = cpu.sel_fb & (cpu.wen | cpu.ren);
	assign cpu_gnt = fb_req & ~fetch_req.en & ~fb_done & (state == ARB_IDLE);

	always_comb begin
		mem_req = fetch_req;
		if (!fetch_req.en) begin
			mem_req.en    = cpu_gnt;
			mem_req.we    = cpu.wen;
			mem_req.addr  = cpu.addr[FB_AW+1:2];
			mem_req.wdata = cpu.wdata[23:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state   <= ARB_IDLE;
			fb_done <= 1'b0;
		end else begin
			state   <= cpu_gnt ? ARB_FLIGHT : ARB_IDLE;
			fb_done <= (state == ARB_FLIGHT) | (fb_done & fb_req);
		end
	end

	always_ff @(posedge clk) begin
		if (state == ARB_FLIGHT)
			fb_rdata_q <= mem_rdata;  // hold it, the fetcher may read next
	end

	assign fetch_rdata = mem_rdata;
	assign ready = cpu.sel_fb ? (fb_done & fb_req) : reg_ready;
	assign rdata = cpu.sel_fb ? {8'b0, fb_rdata_q} : reg_rdata;

	// fetcher cycles only read, any memory write belongs to a cpu grant
	a_one_owner: assert property (@(posedge clk) disable iff (!nrst)
		mem_req.en && mem_req.we |-> cpu_gnt);

endmodule

`default_nettype wire

//--- rtl/pixel_fetch.sv
//--------------------
// walks the framebuffer in address order for the LCD interface
// one read per next_pixel, pix_wait high until the pixel is loaded
//--------------------
`default_nettype none
`timescale 1ns/100ps

module pixel_fetch (
	input  logic               clk,
	input  logic               nrst,
	input  logic               next_pixel,
	output lcd_pkg::mem_req_t  mem_req,
	input  logic [23:0]        mem_rdata,
	output lcd_pkg::pixel_t    pixel,
	output logic               newfield,
	output logic               pix_wait
);
	import lcd_pkg::*;

	logic [FB_AW-1:0] idx;
	logic             rd_pend;      // read goes to memory this cycle
	logic             rd_inflight;  // memory data arrives this cycle

	always_ff @(posedge clk) begin
		if (!nrst) begin
			idx         <= '0;
			rd_pend     <= 1'b1;  // load pixel 0 out of reset
			rd_inflight <= 1'b0;
		end else begin
			rd_inflight <= rd_pend;
			rd_pend     <= next_pixel;
			if (next_pixel) begin
				if (idx == FB_AW'(FB_DEPTH - 1))
					idx <= '0;
				else
					idx <= idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_inflight)
			pixel <= pixel_t'(mem_rdata);
	end

	always_comb begin
		mem_req       = '0;
		mem_req.en    = rd_pend;
		mem_req.we    = 1'b0;
		mem_req.addr  = idx;
		mem_req.wdata = '0;
	end

	assign newfield = (idx == '0);
	assign pix_wait = rd_pend | rd_inflight;

	// the sequencer only advances on a loaded pixel
	a_no_early_advance: assert property (@(posedge clk) disable iff (!nrst)
		next_pixel |-> !pix_wait);

endmodule

`default_nettype wire

//--- sim.f
rtl/lcd_pkg.sv
rtl/fb_ram.sv
rtl/pixel_fetch.sv
rtl/mem_arbiter.sv
rtl/lcd_iface.sv
rtl/lcd_subsys.sv
verification/tb_lcd_subsys.sv

//--- verification/tb_lcd_subsys.sv
//--------------------
// testbench for the LCD subsystem, applies a table of register, panel
// and framebuffer operations and logs every panel write strobe
//--------------------
`default_nettype none
`timescale 1ns/100ps

module tb_lcd_subsys;
	import lcd_pkg::*;

	typedef enum logic [2:0] {
		OP_PINS,    // panel pins straight after reset
		OP_WR,      // register write
		OP_RD,      // register read
		OP_FILL,    // random framebuffer contents
		OP_RENDER,  // two rendered frames
		OP_FBUPD    // framebuffer write and read while rendering
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [7:0]  addr;
		logic [31:0] data;
		logic [31:0] exp_val;
	} row_t;

	typedef struct packed {
		logic              rs;
		logic [LCD_DW-1:0] db;
	} panel_wr_t;

	localparam int          N_ROWS   = 14;
	localparam int          TIMEOUT  = N_ROWS * 40 + 2 * FB_DEPTH * 20;
	localparam logic [31:0] SEED     = 32'h138c;
	localparam logic [7:0]  CTL_ADDR = 8'h08;
	localparam logic [31:0] CTL_ARM  = 32'h0d;  // cs, backlight, render start
	localparam logic [31:0] CTL_STOP = 32'h05;

	logic        clk;
	logic        nrst;
	cpu_req_t    cpu;
	logic [31:0] rdata;
	logic        ready;
	lcd_pins_t   lcd;
	logic        lcd_id;
	logic        lcd_fmark;

	logic [23:0]       fb_model [FB_DEPTH];
	logic [LCD_DW-1:0] start_model;
	panel_wr_t         wr_log [$];      // rs and db at each wr rising edge
	int                rd_pulses = 0;
	logic              wr_prev = 1'b1;
	logic              rd_prev = 1'b1;
	int                cycles;
	int                errors;          // errors in the current row
	int                bad_rows;

	// byte addresses: CMD 00, DATA 04, CTL 08, STATUS 0c, START 10
	row_t table_rows [N_ROWS] = '{
		'{OP_PINS,   8'h00, 32'h0,        32'h1c},
		'{OP_RD,     8'h0c, 32'h2,        32'h2},
		'{OP_RD,     8'h0c, 32'h1,        32'h1},
		'{OP_WR,     8'h08, 32'hffffffe5, 32'h0},
		'{OP_RD,     8'h08, 32'h0,        32'h05},
		'{OP_WR,     8'h10, 32'h12345678, 32'h0},
		'{OP_RD,     8'h10, 32'h0,        32'h05678},
		'{OP_WR,     8'h00, 32'hffff0036, 32'h0},
		'{OP_WR,     8'h04, 32'h5a5a5a5a, 32'h0},
		'{OP_RD,     8'h00, 32'h0,        32'h25a5a},
		'{OP_WR,     8'h10, 32'h0002c,    32'h0},
		'{OP_FILL,   8'h00, 32'h0,        32'h0},
		'{OP_RENDER, 8'h00, 32'h0,        32'h0},
		'{OP_FBUPD,  8'h94, 32'h00c0ffee, 32'h00c0ffee}
	};

	lcd_subsys u_lcd_subsys (
		.clk       (clk),
		.nrst      (nrst),
		.cpu       (cpu),
		.rdata     (rdata),
		.ready     (ready),
		.lcd       (lcd),
		.lcd_id    (lcd_id),
		.lcd_fmark (lcd_fmark)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("run did not finish within %0d cycles", TIMEOUT);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// panel monitor, strobes sampled away from the rising clock edge
	always @(negedge clk) begin
		if (lcd.wr === 1'b1 && wr_prev === 1'b0)
			wr_log.push_back({lcd.rs, lcd.db});
		if (lcd.rd === 1'b1 && rd_prev === 1'b0)
			rd_pulses = rd_pulses + 1;
		wr_prev = lcd.wr;
		rd_prev = lcd.rd;
	end

	// 8:8:8 to 6:6:6, top bits of each colour
	function automatic logic [LCD_DW-1:0] to_666(input logic [23:0] rgb);
		return {rgb[23:18], rgb[15:10], rgb[7:2]};
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("Fail %s: got %h, expected %h", name, got, want);
			errors = errors + 1;
		end
	endtask

	// one cpu transfer, strobe held until ready
	task automatic bus_xfer(input logic sel_fb, input logic [7:0] addr, input logic write,
			input logic [31:0] wdata, output logic [31:0] rd_val);
		@(negedge clk);
		cpu.sel_fb = sel_fb;
		cpu.addr   = addr;
		cpu.wdata  = wdata;
		cpu.wen    = write;
		cpu.ren    = ~write;
		do
			@(negedge clk);
		while (!ready);
		rd_val  = rdata;
		cpu.wen = 1'b0;
		cpu.ren = 1'b0;
		repeat (2) @(negedge clk);  // idle gap, lets the last strobe reach the log
	endtask

	task automatic run_reg(input row_t row, input logic write);
		logic [31:0] got;
		int          wr_before;
		int          rd_before;
		logic        panel;
		reg_addr_e   ra;
		ra        = reg_addr_e'(row.addr[4:2]);
		panel     = (ra == REG_CMD) || (ra == REG_DATA);
		wr_before = wr_log.size();
		rd_before = rd_pulses;
		if (!write) begin
			lcd_id    = row.data[1];
			lcd_fmark = row.data[0];
		end
		bus_xfer(1'b0, row.addr, write, row.data, got);
		if (write && ra == REG_START)
			start_model = row.data[LCD_DW-1:0];
		if (!write)
			check_val("rdata", got, row.exp_val);
		check_val("wr pulses", 32'(wr_log.size() - wr_before), 32'(write && panel));
		check_val("rd pulses", 32'(rd_pulses - rd_before), 32'(!write && panel));
		if (write && panel && wr_log.size() > wr_before) begin
			check_val("rs", 32'(wr_log[wr_before].rs), 32'(ra == REG_DATA));
			check_val("db", 32'(wr_log[wr_before].db), 32'(row.data[LCD_DW-1:0]));
		end
	endtask

	task automatic fill_fb();
		logic [31:0] dummy;
		int          i;
		for (i = 0; i < FB_DEPTH; i++) begin
			fb_model[i] = 24'($urandom());
			bus_xfer(1'b1, 8'(i * 4), 1'b1, 32'(fb_model[i]), dummy);
		end
	endtask

	// start command then one frame of pixels from entry first on
	task automatic check_frame(input int first);
		int i;
		check_val($sformatf("rs entry %0d", first), 32'(wr_log[first].rs), 32'h0);
		check_val($sformatf("db entry %0d", first), 32'(wr_log[first].db), 32'(start_model));
		for (i = 0; i < FB_DEPTH; i++) begin
			check_val($sformatf("rs pixel %0d", i), 32'(wr_log[first + 1 + i].rs), 32'h1);
			check_val($sformatf("db pixel %0d", i), 32'(wr_log[first + 1 + i].db),
				32'(to_666(fb_model[i])));
		end
	endtask

	task automatic run_render();
		logic [31:0] dummy;
		// pixel 0 was fetched before the fill, so stream briefly, stop,
		// then rearm from a nonzero index to make the fetcher wrap to pixel 0
		bus_xfer(1'b0, CTL_ADDR, 1'b1, CTL_ARM, dummy);
		while (wr_log.size() < 4)
			@(negedge clk);
		bus_xfer(1'b0, CTL_ADDR, 1'b1, CTL_STOP, dummy);
		repeat (10) @(negedge clk);
		wr_log.delete();
		bus_xfer(1'b0, CTL_ADDR, 1'b1, CTL_ARM, dummy);
		while (wr_log.size() < 2 * (FB_DEPTH + 1))
			@(negedge clk);
		check_frame(0);
		check_frame(FB_DEPTH + 1);
	endtask

	task automatic run_fb_update(input row_t row);
		logic [31:0] got;
		int          mark;
		int          first;
		fb_model[row.addr[7:2]] = row.data[23:0];
		bus_xfer(1'b1, row.addr, 1'b1, row.data, got);
		bus_xfer(1'b1, row.addr, 1'b0, 32'h0, got);
		check_val("rdata", got, row.exp_val);
		mark = wr_log.size();
		while (wr_log.size() < mark + 2 * (FB_DEPTH + 1))
			@(negedge clk);
		first = mark;
		while (first < mark + FB_DEPTH + 1 && wr_log[first].rs !== 1'b0)
			first++;  // first frame start after the update
		check_frame(first);
	endtask

	initial begin
		int i;
		void'($urandom(SEED));
		nrst        = 1'b0;
		cpu         = '0;
		lcd_id      = 1'b0;
		lcd_fmark   = 1'b0;
		bad_rows    = 0;
		start_model = START_CMD_RST;
		repeat (3) @(negedge clk);
		nrst = 1'b1;
		for (i = 0; i < N_ROWS; i++) begin
			errors = 0;
			case (table_rows[i].op)
				OP_PINS:   check_val("pins wr,rd,cs,rst,blen",
					32'({lcd.wr, lcd.rd, lcd.cs, lcd.rst, lcd.blen}), table_rows[i].exp_val);
				OP_WR:     run_reg(table_rows[i], 1'b1);
				OP_RD:     run_reg(table_rows[i], 1'b0);
				OP_FILL:   fill_fb();
				OP_RENDER: run_render();
				OP_FBUPD:  run_fb_update(table_rows[i]);
				default: begin
					$display("row %0d holds an unknown operation", i);
					errors = errors + 1;
				end
			endcase
			if (errors == 0) begin
				$display("test %0d %s addr %h: ok", i, table_rows[i].op.name(),
					table_rows[i].addr);
			end else begin
				$display("test %0d %s addr %h: %0d errors", i, table_rows[i].op.name(),
					table_rows[i].addr, errors);
				bad_rows = bad_rows + 1;
			end
		end
		$display("%0d tests, %0d ok, %0d with errors", N_ROWS, N_ROWS - bad_rows, bad_rows);
		if (bad_rows == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
